// ==== source/abus_consts.svh ====
// Width, region-code and device-page constants of the address-bus controller; include where needed
`ifndef ABUS_CONSTS_SVH
`define ABUS_CONSTS_SVH

// Bus address width
`define ABUS_ADDR_W 24

// Multiplexed DRAM address width
`define ABUS_MA_W 11

// Config read-back bus width
`define ABUS_DATA_W 16

// Row shift before the bank column and width adjustment
`define ABUS_ROW_BASE 8

// Internal device page on address bits 20:16
`define ABUS_INTDEV_PAGE 5'b00001

// Device window on address bits 20:17
`define ABUS_DEV_WIN 4'b1000

// 32-bit device code on address bits 20:15
`define ABUS_DEV32_CODE 6'b100001

// DRAM banks with an open-row register each
`define ABUS_NBANKS 2

`endif

// ==== source/abus_pkg.sv ====
// Shared types of the address-bus controller, compiled before every RTL module that uses them
`default_nettype none

`include "abus_consts.svh"

package abus_pkg;

	// Bus address as seen on the CPU side
	typedef logic [`ABUS_ADDR_W-1:0] addr_t;

	// Row or column address driven to the DRAMs
	typedef logic [`ABUS_MA_W-1:0] ma_t;

	// Config word on the read-back bus
	typedef logic [`ABUS_DATA_W-1:0] data_t;

	// Port width code, 0 is 8 bits up to 3 for 64 bits
	typedef logic [1:0] width_t;

	// Column-count code of a DRAM bank
	typedef logic [1:0] cols_t;

	// Bank selects
	// bit 0 low ROM, bit 1 upper ROM, bit 2 DRAM bank 1, bit 3 DRAM bank 0
	typedef logic [3:0] bs_t;

	// Both config words, MEMCON1 fields first
	typedef struct packed {
		logic romhi;
		width_t romwid;
		logic [1:0] romspd;
		logic [1:0] dspd;
		logic fastrom;
		logic [1:0] iospd;
		logic nocpu;
		logic cpu32;
		cols_t cols0;
		width_t dwid0;
		cols_t cols1;
		width_t dwid1;
		logic bigend;
		logic hilo;
	} memcon_t;

	// Held address and its registered decode
	typedef struct packed {
		addr_t addr;
		bs_t bs;
		logic dram;
		logic intdev;
		width_t mw;
		logic bank1;
	} decode_t;

endpackage

`default_nettype wire

// ==== source/memcon_regs.sv ====
// MEMCON1/MEMCON2 config registers, configured flag and read-back mux; one instance in abus_ctrl
`default_nettype none

module memcon_regs (
	input wire logic sys_clk,
	input wire logic resetl,
	input abus_pkg::data_t din,
	input wire logic memc1w,
	input wire logic memc2w,
	input wire logic memc1r,
	input wire logic memc2r,
	output abus_pkg::memcon_t cfg,
	output logic configured,
	output abus_pkg::data_t dr_out,
	output logic dr_oe
);

	abus_pkg::data_t word1;
	abus_pkg::data_t word2;

	// Config words, loaded by their own write strobe
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			cfg <= '0;
		end else begin
			if (memc1w) begin
				cfg.romhi <= din[0];
				cfg.romwid <= din[2:1];
				cfg.romspd <= din[4:3];
				cfg.dspd <= din[6:5];
				cfg.fastrom <= din[7];
				cfg.iospd <= din[12:11];
				cfg.nocpu <= din[13];
				cfg.cpu32 <= din[14];
			end
			if (memc2w) begin
				cfg.cols0 <= din[1:0];
				cfg.dwid0 <= din[3:2];
				cfg.cols1 <= din[5:4];
				cfg.dwid1 <= din[7:6];
				cfg.bigend <= din[12];
				cfg.hilo <= din[13];
			end
		end
	end

	// First MEMCON1 write switches decode to the configured map
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			configured <= 1'b0;
		end else if (memc1w) begin
			configured <= 1'b1;
		end
	end

	// Read-back images, unused bits zero
	assign word1 = {1'b0, cfg.cpu32, cfg.nocpu, cfg.iospd, 3'b000, cfg.fastrom,
		cfg.dspd, cfg.romspd, cfg.romwid, cfg.romhi};
	assign word2 = {2'b00, cfg.hilo, cfg.bigend, 4'h0, cfg.dwid1, cfg.cols1,
		cfg.dwid0, cfg.cols0};

	// Both reads at once OR the words together, as the shared bus would
	assign dr_out = (memc1r ? word1 : '0) | (memc2r ? word2 : '0);
	assign dr_oe = memc1r | memc2r;

	// Only reset may take the controller back to the boot map
	configured_sticky: assert property (
		@(posedge sys_clk) disable iff (!resetl)
		configured |=> configured
	);

endmodule

`default_nettype wire

// ==== source/addr_decode.sv ====
// Stage 1 of the controller; latches the bus address on ack and registers the region decode
`default_nettype none

`include "abus_consts.svh"

module addr_decode (
	input wire logic sys_clk,
	input wire logic resetl,
	input abus_pkg::addr_t a_in,
	input wire logic ack,
	input wire logic mreq,
	input abus_pkg::memcon_t cfg,
	input wire logic configured,
	output abus_pkg::decode_t dec
);

	logic [2:0] rgn;
	logic dev_win;
	logic dev32;
	logic low_rgn;
	abus_pkg::decode_t dec_nxt;

	// Region code, complemented when the ROM sits at the top
	assign rgn = cfg.romhi ? ~a_in[23:21] : a_in[23:21];

	// Device window and its 32-bit sub-page
	assign dev_win = (a_in[20:17] == `ABUS_DEV_WIN);
	assign dev32 = (a_in[20:15] == `ABUS_DEV32_CODE);

	// Boot ROM region, or the whole map before configuration
	assign low_rgn = !configured || (rgn == 3'b000);

	always_comb begin
		dec_nxt = '0;
		dec_nxt.addr = a_in;
		// No memory cycle, no selects
		if (mreq) begin
			if (!configured) begin
				// Boot map, ROM everywhere except the device window
				dec_nxt.bs[0] = !dev_win;
			end else begin
				dec_nxt.bs[0] = (rgn == 3'b000) && !dev_win;
				dec_nxt.bs[1] = (rgn == 3'b001) || (rgn[2:1] == 2'b01);
				dec_nxt.bs[2] = (rgn[2:1] == 2'b10);
				dec_nxt.bs[3] = (rgn[2:1] == 2'b11);
			end
			dec_nxt.dram = dec_nxt.bs[2] | dec_nxt.bs[3];
			dec_nxt.bank1 = dec_nxt.bs[2];
			dec_nxt.intdev = low_rgn && (a_in[20:16] == `ABUS_INTDEV_PAGE);
			// Port width of whatever answers
			if (dec_nxt.bs[0] || dec_nxt.bs[1]) begin
				dec_nxt.mw = cfg.romwid;
			end else if (dec_nxt.bs[2]) begin
				dec_nxt.mw = cfg.dwid1;
			end else if (dec_nxt.bs[3]) begin
				dec_nxt.mw = cfg.dwid0;
			end else if (low_rgn && dev_win) begin
				dec_nxt.mw = dev32 ? 2'd2 : 2'd1;
			end
		end
	end

	// Held until the next ack
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			dec <= '0;
		end else if (ack) begin
			dec <= dec_nxt;
		end
	end

	// Never more than one device selected
	bs_onehot: assert property (
		@(posedge sys_clk) disable iff (!resetl)
		ack |=> $onehot0(dec.bs)
	);

endmodule

`default_nettype wire

// ==== source/dram_addr_mux.sv ====
// Stage 2 of the controller; forms DRAM row and column addresses and registers ma
`default_nettype none

`include "abus_consts.svh"

module dram_addr_mux (
	input wire logic sys_clk,
	input wire logic resetl,
	input abus_pkg::decode_t dec,
	input abus_pkg::memcon_t cfg,
	input wire logic mux,
	output abus_pkg::ma_t row,
	output abus_pkg::ma_t ma
);

	abus_pkg::width_t dwid;
	abus_pkg::cols_t cols;
	logic [4:0] row_shift;
	abus_pkg::ma_t col;

	// Geometry of the bank being addressed
	assign dwid = dec.bank1 ? cfg.dwid1 : cfg.dwid0;
	assign cols = dec.bank1 ? cfg.cols1 : cfg.cols0;

	// Column drops the byte lanes of the bank width
	assign col = abus_pkg::ma_t'(dec.addr >> dwid);

	// Row sits above the column bits
	// at most 8+3+3
	assign row_shift = 5'(`ABUS_ROW_BASE) + {3'b000, dwid} + {3'b000, cols};
	assign row = abus_pkg::ma_t'(dec.addr >> row_shift);

	// RAS phase drives the row, CAS phase the column
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			ma <= '0;
		end else begin
			ma <= mux ? row : col;
		end
	end

endmodule

`default_nettype wire

// ==== source/page_match.sv ====
// Open-row registers of the DRAM banks and page-hit compare; one instance in abus_ctrl
`default_nettype none

`include "abus_consts.svh"

module page_match (
	input wire logic sys_clk,
	input wire logic resetl,
	input abus_pkg::decode_t dec,
	input abus_pkg::ma_t row,
	input wire logic newrow,
	input wire logic resrow,
	output logic match
);

	abus_pkg::ma_t open_row [`ABUS_NBANKS];
	logic [`ABUS_NBANKS-1:0] row_valid;

	// Row opened by the controller, only for DRAM cycles
	always_ff @(posedge sys_clk) begin
		if (newrow && dec.dram) begin
			open_row[dec.bank1] <= row;
		end
	end

	// Refresh or precharge closes every bank
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			row_valid <= '0;
		end else if (resrow) begin
			row_valid <= '0;
		end else if (newrow && dec.dram) begin
			row_valid[dec.bank1] <= 1'b1;
		end
	end

	// Hit when the addressed bank already has this row open
	assign match = dec.dram && row_valid[dec.bank1] && (open_row[dec.bank1] == row);

	// Opening a row gives a hit on the same address next cycle
	open_then_hit: assert property (
		@(posedge sys_clk) disable iff (!resetl)
		(newrow && dec.dram && !resrow) |=> (match || $changed(dec) || $changed(row))
	);

endmodule

`default_nettype wire

// ==== source/abus_ctrl.sv ====
// Address-bus controller top; config registers, decode, DRAM address and page-hit stages
`default_nettype none

module abus_ctrl (
	input wire logic sys_clk,
	input wire logic resetl,
	input abus_pkg::addr_t a_in,
	input wire logic ack,
	input wire logic mreq,
	input wire logic mux,
	input abus_pkg::data_t din,
	input wire logic memc1w,
	input wire logic memc2w,
	input wire logic memc1r,
	input wire logic memc2r,
	input wire logic newrow,
	input wire logic resrow,
	output abus_pkg::addr_t aout,
	output abus_pkg::bs_t bs,
	output logic dram,
	output logic intdev,
	output abus_pkg::width_t mw,
	output abus_pkg::ma_t ma,
	output logic match,
	output logic bigend,
	output logic hilo,
	output abus_pkg::data_t dr_out,
	output logic dr_oe
);

	abus_pkg::memcon_t cfg;
	logic configured;
	abus_pkg::decode_t dec;
	abus_pkg::ma_t row;

	memcon_regs memcon_regs_i (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.din(din),
		.memc1w(memc1w),
		.memc2w(memc2w),
		.memc1r(memc1r),
		.memc2r(memc2r),
		.cfg(cfg),
		.configured(configured),
		.dr_out(dr_out),
		.dr_oe(dr_oe)
	);

	// Stage 1
	addr_decode addr_decode_i (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.a_in(a_in),
		.ack(ack),
		.mreq(mreq),
		.cfg(cfg),
		.configured(configured),
		.dec(dec)
	);

	// Stage 2
	dram_addr_mux dram_addr_mux_i (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.dec(dec),
		.cfg(cfg),
		.mux(mux),
		.row(row),
		.ma(ma)
	);

	page_match page_match_i (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.dec(dec),
		.row(row),
		.newrow(newrow),
		.resrow(resrow),
		.match(match)
	);

	// Decode fields out to the memory interface
	assign aout = dec.addr;
	assign bs = dec.bs;
	assign dram = dec.dram;
	assign intdev = dec.intdev;
	assign mw = dec.mw;

	// Byte order controls straight from MEMCON2
	assign bigend = cfg.bigend;
	assign hilo = cfg.hilo;

endmodule

`default_nettype wire

// ==== dv/abus_ref_model.svh ====
// Reference model of the address-bus controller; included inside the testbench module
`ifndef ABUS_REF_MODEL_SVH
`define ABUS_REF_MODEL_SVH

// MEMCON1 keeps bits 7:0 and 14:11
function automatic abus_pkg::data_t memcon1_image(input abus_pkg::data_t d);
	return d & 16'h78ff;
endfunction

// MEMCON2 keeps bits 7:0, 12 and 13
function automatic abus_pkg::data_t memcon2_image(input abus_pkg::data_t d);
	return d & 16'h30ff;
endfunction

// Decode taken on one ack, w1 and w2 are the register images
function automatic abus_pkg::decode_t expect_decode(input abus_pkg::addr_t a, input logic mreq,
	input logic cfgd, input abus_pkg::data_t w1, input abus_pkg::data_t w2);
	abus_pkg::decode_t d;
	logic [2:0] r;
	logic devwin;
	d = '0;
	d.addr = a;
	// ROM at the top flips every region code
	r = a[23:21] ^ {3{w1[0]}};
	devwin = (a[20:17] == `ABUS_DEV_WIN);
	if (!mreq) begin
		return d;
	end
	if (cfgd) begin
		d.bs = {r[2:1] == 2'b11, r[2:1] == 2'b10, (r == 3'b001) || (r[2:1] == 2'b01),
			(r == 3'b000) && !devwin};
	end else begin
		d.bs = {3'b000, !devwin};
	end
	d.dram = d.bs[2] || d.bs[3];
	d.bank1 = d.bs[2];
	d.intdev = (a[20:16] == `ABUS_INTDEV_PAGE) && (!cfgd || (r == 3'b000));
	// Width of whichever device answers, unmapped stays 0
	if (d.bs[1:0] != 2'b00) begin
		d.mw = w1[2:1];
	end else if (d.bs[3]) begin
		d.mw = w2[3:2];
	end else if (d.bs[2]) begin
		d.mw = w2[7:6];
	end else if (devwin) begin
		d.mw = (a[20:15] == `ABUS_DEV32_CODE) ? 2'd2 : 2'd1;
	end
	return d;
endfunction

// Column address, byte lanes of the bank dropped
function automatic abus_pkg::ma_t expect_col(input abus_pkg::addr_t a, input logic bank1,
	input abus_pkg::data_t w2);
	logic [1:0] dwid;
	dwid = bank1 ? w2[7:6] : w2[3:2];
	return abus_pkg::ma_t'(a >> dwid);
endfunction

// Row address, above the column bits of the bank
function automatic abus_pkg::ma_t expect_row(input abus_pkg::addr_t a, input logic bank1,
	input abus_pkg::data_t w2);
	int sh;
	sh = `ABUS_ROW_BASE + int'(bank1 ? w2[7:6] : w2[3:2]) + int'(bank1 ? w2[5:4] : w2[1:0]);
	if (sh > 14) begin
		return '0;
	end
	return abus_pkg::ma_t'(a >> sh);
endfunction

`endif

// ==== dv/abus_ctrl_tb.sv ====
// Self-checking testbench of abus_ctrl; seeded random bus traffic checked against a model
`default_nettype none

`include "abus_consts.svh"

module abus_ctrl_tb;

	// Test lengths in cycles, they also size the watchdog
	localparam int BOOT_CYC = 120;
	localparam int CFG_CYC = 80;
	localparam int DEC_ROUNDS = 8;
	localparam int DEC_CYC = 40;
	localparam int B2B_CYC = 200;
	localparam int PAGE_CYC = 300;
	localparam int RST_CYC = 40;
	localparam int TOTAL_CYC = BOOT_CYC + CFG_CYC + DEC_ROUNDS * (DEC_CYC + 2) + B2B_CYC
		+ PAGE_CYC + 3 * RST_CYC + 20;

	// All DUT inputs of one cycle
	typedef struct packed {
		abus_pkg::addr_t a;
		abus_pkg::data_t din;
		logic ack;
		logic mreq;
		logic mux;
		logic newrow;
		logic resrow;
		logic memc1w;
		logic memc2w;
		logic memc1r;
		logic memc2r;
	} stim_t;

	logic sys_clk;
	logic resetl;
	stim_t drv;
	abus_pkg::addr_t aout;
	abus_pkg::bs_t bs;
	logic dram;
	logic intdev;
	abus_pkg::width_t mw;
	abus_pkg::ma_t ma;
	logic match;
	logic bigend;
	logic hilo;
	abus_pkg::data_t dr_out;
	logic dr_oe;

	// Model of registers, held decode, ma and open rows
	abus_pkg::data_t m1;
	abus_pkg::data_t m2;
	logic m_cfgd;
	abus_pkg::decode_t h_dec;
	abus_pkg::ma_t e_ma;
	abus_pkg::ma_t m_row [`ABUS_NBANKS];
	logic [`ABUS_NBANKS-1:0] m_val;
	abus_pkg::addr_t pool [6];

	int checks;
	int test_errs;
	int total_errs;
	int tests_run;
	int tests_failed;

	`include "abus_ref_model.svh"

	abus_ctrl dut_i (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.a_in(drv.a),
		.ack(drv.ack),
		.mreq(drv.mreq),
		.mux(drv.mux),
		.din(drv.din),
		.memc1w(drv.memc1w),
		.memc2w(drv.memc2w),
		.memc1r(drv.memc1r),
		.memc2r(drv.memc2r),
		.newrow(drv.newrow),
		.resrow(drv.resrow),
		.aout(aout),
		.bs(bs),
		.dram(dram),
		.intdev(intdev),
		.mw(mw),
		.ma(ma),
		.match(match),
		.bigend(bigend),
		.hilo(hilo),
		.dr_out(dr_out),
		.dr_oe(dr_oe)
	);

	// Starts high so the first falling edge comes before the first rising one
	initial begin
		sys_clk = 1'b1;
		forever begin
			#10 sys_clk = ~sys_clk;
		end
	end

	initial begin
		#(TOTAL_CYC * 20 + 1000);
		$display("Watchdog expired, the tests did not reach their end");
		$display("Some tests failed");
		$finish;
	end

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			$display("[FAIL] time %0t %s expected %0h actual %0h", $time, name, expected, actual);
			test_errs++;
		end
	endtask

	// Outputs left by the last rising edge, read before the next drive
	task automatic check_outputs();
		abus_pkg::data_t rd;
		logic hit;
		rd = (drv.memc1r ? m1 : '0) | (drv.memc2r ? m2 : '0);
		hit = h_dec.dram && m_val[h_dec.bank1]
			&& (m_row[h_dec.bank1] == expect_row(h_dec.addr, h_dec.bank1, m2));
		compare("aout", 32'(h_dec.addr), 32'(aout));
		compare("bs", 32'(h_dec.bs), 32'(bs));
		compare("dram", 32'(h_dec.dram), 32'(dram));
		compare("intdev", 32'(h_dec.intdev), 32'(intdev));
		compare("mw", 32'(h_dec.mw), 32'(mw));
		compare("ma", 32'(e_ma), 32'(ma));
		compare("match", 32'(hit), 32'(match));
		compare("bigend", 32'(m2[12]), 32'(bigend));
		compare("hilo", 32'(m2[13]), 32'(hilo));
		compare("dr_out", 32'(rd), 32'(dr_out));
		compare("dr_oe", 32'(drv.memc1r | drv.memc2r), 32'(dr_oe));
	endtask

	// Check, step the model across the coming rising edge, then drive
	task automatic run_cycle(input stim_t s);
		abus_pkg::decode_t nd;
		abus_pkg::ma_t row_now;
		@(negedge sys_clk);
		check_outputs();
		// Everything below sees the state before the edge
		nd = expect_decode(s.a, s.mreq, m_cfgd, m1, m2);
		row_now = expect_row(h_dec.addr, h_dec.bank1, m2);
		e_ma = s.mux ? row_now : expect_col(h_dec.addr, h_dec.bank1, m2);
		if (s.resrow) begin
			m_val = '0;
		end else if (s.newrow && h_dec.dram) begin
			m_row[h_dec.bank1] = row_now;
			m_val[h_dec.bank1] = 1'b1;
		end
		if (s.ack) begin
			h_dec = nd;
		end
		if (s.memc1w) begin
			m1 = memcon1_image(s.din);
			m_cfgd = 1'b1;
		end
		if (s.memc2w) begin
			m2 = memcon2_image(s.din);
		end
		drv = s;
	endtask

	// Three rising edges with resetl low
	task automatic apply_reset();
		@(negedge sys_clk);
		resetl = 1'b0;
		drv = '0;
		repeat (3) @(negedge sys_clk);
		resetl = 1'b1;
		m1 = '0;
		m2 = '0;
		m_cfgd = 1'b0;
		h_dec = '0;
		e_ma = '0;
		m_val = '0;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errs != 0) begin
			tests_failed++;
		end
		$display("test %s %s, %0d mismatches", name, (test_errs == 0) ? "ok" : "FAILED",
			test_errs);
		total_errs += test_errs;
		test_errs = 0;
	endtask

	// Random address, a quarter of the draws each in a device page
	function automatic abus_pkg::addr_t rand_addr();
		abus_pkg::addr_t a;
		a = abus_pkg::addr_t'($urandom);
		case ($urandom % 4)
			1: a[20:16] = `ABUS_INTDEV_PAGE;
			2: a[20:15] = `ABUS_DEV32_CODE;
			3: a[20:17] = `ABUS_DEV_WIN;
			default: ;
		endcase
		return a;
	endfunction

	function automatic stim_t bus_stim(input int ack_pct, input int mreq_pct);
		stim_t s;
		s = '0;
		s.a = rand_addr();
		s.ack = ($urandom % 100) < ack_pct;
		s.mreq = ($urandom % 100) < mreq_pct;
		s.mux = 1'($urandom);
		return s;
	endfunction

	// MEMCON1 then MEMCON2, random contents
	task automatic write_config();
		stim_t s;
		s = '0;
		s.din = abus_pkg::data_t'($urandom);
		s.memc1w = 1'b1;
		run_cycle(s);
		s = '0;
		s.din = abus_pkg::data_t'($urandom);
		s.memc2w = 1'b1;
		run_cycle(s);
	endtask

	initial begin
		stim_t s;
		abus_pkg::addr_t base;
		logic [2:0] pick;
		abus_pkg::data_t w1_keep;
		abus_pkg::data_t w2_keep;
		void'($urandom(31650));
		resetl = 1'b0;
		drv = '0;
		checks = 0;
		test_errs = 0;
		total_errs = 0;
		tests_run = 0;
		tests_failed = 0;
		apply_reset();

		// Boot map, no MEMCON1 write yet
		repeat (BOOT_CYC) begin
			run_cycle(bus_stim(80, 80));
		end
		end_test("boot_decode");

		// Writes and reads in any mix, both reads together too
		repeat (CFG_CYC) begin
			s = '0;
			s.din = abus_pkg::data_t'($urandom);
			{s.memc1w, s.memc2w, s.memc1r, s.memc2r} = 4'($urandom);
			run_cycle(s);
		end
		end_test("config_rw");

		repeat (DEC_ROUNDS) begin
			write_config();
			repeat (DEC_CYC) begin
				run_cycle(bus_stim(75, 75));
			end
		end
		end_test("config_decode");

		// ack on every edge, two addresses in flight
		repeat (B2B_CYC) begin
			run_cycle(bus_stim(100, 100));
		end
		end_test("ma_b2b");

		// Pairs of DRAM addresses sharing a row
		for (int i = 0; i < 6; i += 2) begin
			base = rand_addr();
			base[23] = ~m1[0];
			pool[i] = base;
			pool[i + 1] = base ^ abus_pkg::addr_t'($urandom % 256);
		end
		repeat (PAGE_CYC) begin
			s = bus_stim(50, 90);
			pick = 3'($urandom % 6);
			s.a = pool[pick];
			s.newrow = ($urandom % 100) < 30;
			s.resrow = ($urandom % 100) < 8;
			run_cycle(s);
		end
		end_test("page_match");

		// Rows of the pool left open when reset arrives
		repeat (RST_CYC) begin
			s = bus_stim(70, 90);
			pick = 3'($urandom % 6);
			s.a = pool[pick];
			s.newrow = 1'($urandom);
			run_cycle(s);
		end
		w1_keep = m1;
		w2_keep = m2;
		apply_reset();
		// Back in the boot map with empty registers
		repeat (RST_CYC) begin
			s = bus_stim(70, 90);
			s.memc1r = 1'($urandom);
			run_cycle(s);
		end
		// Same map and geometry again, so stale open rows would hit
		s = '0;
		s.din = w1_keep;
		s.memc1w = 1'b1;
		run_cycle(s);
		s = '0;
		s.din = w2_keep;
		s.memc2w = 1'b1;
		run_cycle(s);
		repeat (RST_CYC) begin
			s = bus_stim(70, 90);
			pick = 3'($urandom % 6);
			s.a = pool[pick];
			run_cycle(s);
		end
		run_cycle('0);
		end_test("mid_reset");

		$display("tests run %0d, failed %0d, checks %0d, mismatches %0d", tests_run,
			tests_failed, checks, total_errs);
		if (tests_failed == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== abus_ctrl.f ====
+incdir+source
+incdir+dv
source/abus_pkg.sv
source/memcon_regs.sv
source/addr_decode.sv
source/dram_addr_mux.sv
source/page_match.sv
source/abus_ctrl.sv
dv/abus_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the abus_ctrl testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module abus_ctrl_tb \
	-f abus_ctrl.f -o abus_ctrl_sim

./obj_dir/abus_ctrl_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Some tests failed" sim.log; then
	echo "Simulation reported failures, see sim.log"
	exit 1
fi
echo "Simulation finished without failures"
